// File: source/rcc_pkg.sv
// --------------------
// register map and word layout for the reset-cause block
// core k status word sits at 0x04 + 4*k, word aligned only
// bit 18 and bits 15..0 of the status word read as zero
// --------------------
package rcc_pkg;

  // --------------------
  // widths
  // --------------------
  // data word
  localparam int rcc_data_w = 32;
  // byte address
  localparam int rcc_addr_w = 8;
  // reset sources per core
  localparam int num_rst_src = 14;

  // one bit per reset source
  // msb to lsb: lpwr2 lpwr1 wwdg2 wwdg1 iwdg2 iwdg1 sft2 sft1 por pin bor d2 d1 obl
  typedef logic [num_rst_src-1:0] rst_src_t;

  // bit positions inside rst_src_t that the logic refers to by name
  localparam int src_obl   = 0;
  localparam int src_d1    = 1;
  localparam int src_por   = 5;
  localparam int src_lpwr2 = 13;

  // --------------------
  // address map
  // --------------------
  // control/status word
  localparam logic [rcc_addr_w-1:0] addr_csr      = 8'h00;
  // core 0 reset status word
  localparam logic [rcc_addr_w-1:0] addr_rsr_base = 8'h04;

  // --------------------
  // word views
  // --------------------
  // reset status view, one per core
  typedef struct packed {
    // lpwr2 down to d1, same order as rst_src_t
    logic [num_rst_src-2:0] rstf;
    logic                   rsvd18;
    // option byte load
    logic                   oblrstf;
    // remove flags, holds the core's flags clear while set
    logic                   rmvf;
    logic [15:0]            rsvd_lo;
  } rsr_view_t;

  // control/status view
  typedef struct packed {
    logic [rcc_data_w-2:0] rsvd;
    // low speed oscillator enable
    logic                  lsion;
  } csr_view_t;

  // one bus word, read either way depending on the address
  typedef union packed {
    rsr_view_t rsr;
    csr_view_t csr;
  } rcc_word_u;

  // --------------------
  // register select
  // --------------------
  // sel_none covers unknown and misaligned addresses
  typedef enum logic [1:0] {
    sel_csr,
    sel_rsr,
    sel_none
  } reg_sel_e;

endpackage

// File: source/rcc_reg_decode.sv
// --------------------
// one access in flight, the next req is taken after ack was seen
// cmd_valid pulses one cycle, one edge after req is first seen high
// --------------------
`timescale 1ns/1ps

module rcc_reg_decode #(
  parameter int num_cpu = 2,
  localparam int cpu_w = (num_cpu > 1) ? $clog2(num_cpu) : 1
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req,
  input  logic                          wr,
  input  logic [rcc_pkg::rcc_addr_w-1:0] addr,
  input  rcc_pkg::rcc_word_u            wdata,
  input  logic                          ack,
  output logic                          cmd_valid,
  output logic                          cmd_wr,
  output rcc_pkg::reg_sel_e             cmd_sel,
  output logic [cpu_w-1:0]              cmd_cpu,
  output rcc_pkg::rcc_word_u            cmd_wdata
);
  import rcc_pkg::*;

  // set from acceptance until ack is seen
  logic                  busy;
  // accepted, command issues on the next edge
  logic                  pend;
  logic                  accept;
  // address relative to core 0 status word
  logic [rcc_addr_w-1:0] rsr_off;
  logic [rcc_addr_w-3:0] rsr_idx;
  reg_sel_e              sel_d;
  logic [cpu_w-1:0]      cpu_d;

  // new request, previous one fully closed
  assign accept = req && !ack && !busy;

  // --------------------
  // address decode
  // --------------------
  assign rsr_off = addr - addr_rsr_base;
  assign rsr_idx = rsr_off[rcc_addr_w-1:2];

  always_comb begin
    sel_d = sel_none;
    cpu_d = '0;
    if (addr[1:0] != 2'b00) begin
      // misaligned, nothing selected
      sel_d = sel_none;
    end else if (addr == addr_csr) begin
      sel_d = sel_csr;
    end else if ((addr >= addr_rsr_base) && (int'(rsr_idx) < num_cpu)) begin
      sel_d = sel_rsr;
      cpu_d = rsr_idx[cpu_w-1:0];
    end
  end

  // --------------------
  // handshake state
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      pend      <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      // pend delays issue by one cycle
      pend      <= accept;
      cmd_valid <= pend;
      if (accept) begin
        busy <= 1'b1;
      end else if (ack) begin
        busy <= 1'b0;
      end
    end
  end

  // command fields, captured on accept and stable while cmd_valid is high
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_wr    <= wr;
      cmd_sel   <= sel_d;
      cmd_cpu   <= cpu_d;
      cmd_wdata <= wdata;
    end
  end

endmodule

// File: source/rcc_rst_flags.sv
// --------------------
// flags are sticky until the core's rmvf is written 1
// every source sets the same flag in every core
// por flag comes out of rst set, all other state clears
// --------------------
`timescale 1ns/1ps

module rcc_rst_flags #(
  parameter int num_cpu = 2,
  localparam int cpu_w = (num_cpu > 1) ? $clog2(num_cpu) : 1
) (
  input  logic                            clk,
  input  logic                            rst,
  input  rcc_pkg::rst_src_t               rst_src,
  input  logic                            cmd_valid,
  input  logic                            cmd_wr,
  input  rcc_pkg::reg_sel_e               cmd_sel,
  input  logic [cpu_w-1:0]                cmd_cpu,
  input  rcc_pkg::rcc_word_u              cmd_wdata,
  output rcc_pkg::rst_src_t [num_cpu-1:0] flags,
  output logic [num_cpu-1:0]              rmvf,
  output logic                            lsion
);
  import rcc_pkg::*;

  // value after rst, only the power-on flag set
  localparam rst_src_t flags_rst_val = rst_src_t'(1) << src_por;

  // write strobes, one cycle wide
  logic csr_we;
  logic rsr_we;

  assign csr_we = cmd_valid && cmd_wr && (cmd_sel == sel_csr);
  assign rsr_we = cmd_valid && cmd_wr && (cmd_sel == sel_rsr);

  // --------------------
  // per core status
  // --------------------
  for (genvar k = 0; k < num_cpu; k++) begin : g_core

    // remove-flags bit, written through the status view only
    always_ff @(posedge clk) begin
      if (rst) begin
        rmvf[k] <= 1'b0;
      end else if (rsr_we && (cmd_cpu == k[cpu_w-1:0])) begin
        rmvf[k] <= cmd_wdata.rsr.rmvf;
      end
    end

    // sticky flags
    always_ff @(posedge clk) begin
      if (rst) begin
        flags[k] <= flags_rst_val;
      end else if (rmvf[k]) begin
        // rmvf wins over any source pulse
        flags[k] <= '0;
      end else begin
        // accumulate, a flag never clears by itself
        flags[k] <= flags[k] | rst_src;
      end
    end

  end

  // --------------------
  // control/status
  // --------------------
  // lsion lives in bit 0, upper wdata bits ignored
  always_ff @(posedge clk) begin
    if (rst) begin
      lsion <= 1'b0;
    end else if (csr_we) begin
      lsion <= cmd_wdata.csr.lsion;
    end
  end

endmodule

// File: source/rcc_read_result.sv
// --------------------
// result comes one edge after cmd_valid, writes read back zero
// ack holds until req is seen low
// --------------------
`timescale 1ns/1ps

module rcc_read_result #(
  parameter int num_cpu = 2,
  localparam int cpu_w = (num_cpu > 1) ? $clog2(num_cpu) : 1
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            req,
  input  logic                            cmd_valid,
  input  logic                            cmd_wr,
  input  rcc_pkg::reg_sel_e               cmd_sel,
  input  logic [cpu_w-1:0]                cmd_cpu,
  input  rcc_pkg::rst_src_t [num_cpu-1:0] flags,
  input  logic [num_cpu-1:0]              rmvf,
  input  logic                            lsion,
  output logic                            ack,
  output rcc_pkg::rcc_word_u              rdata,
  output logic                            err
);
  import rcc_pkg::*;

  // read word for the selected register
  rcc_word_u rd_word;

  // --------------------
  // read mux
  // --------------------
  always_comb begin
    rd_word = '0;
    case (cmd_sel)
      sel_csr: rd_word.csr.lsion = lsion;
      sel_rsr: begin
        // source order in the word matches rst_src_t
        rd_word.rsr.rstf    = flags[cmd_cpu][src_lpwr2:src_d1];
        rd_word.rsr.oblrstf = flags[cmd_cpu][src_obl];
        rd_word.rsr.rmvf    = rmvf[cmd_cpu];
      end
      default: rd_word = '0;
    endcase
  end

  // --------------------
  // response
  // --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      ack   <= 1'b0;
      err   <= 1'b0;
      rdata <= '0;
    end else if (cmd_valid) begin
      ack   <= 1'b1;
      err   <= (cmd_sel == sel_none);
      // zero for writes and for unmapped addresses
      rdata <= (cmd_wr || (cmd_sel == sel_none)) ? '0 : rd_word;
    end else if (!req) begin
      // master has let go, close the handshake
      ack <= 1'b0;
    end
  end

endmodule

// File: source/rcc_vdd_reg.sv
// --------------------
// reset-cause status and lsion for num_cpu cores
// four-phase req/ack, one access at a time
// --------------------
`timescale 1ns/1ps

module rcc_vdd_reg #(
  parameter int num_cpu = 2,
  localparam int cpu_w = (num_cpu > 1) ? $clog2(num_cpu) : 1
) (
  input  logic                           clk,
  input  logic                           rst,
  // register port
  input  logic                           req,
  input  logic                           wr,
  input  logic [rcc_pkg::rcc_addr_w-1:0] addr,
  input  rcc_pkg::rcc_word_u             wdata,
  output logic                           ack,
  output rcc_pkg::rcc_word_u             rdata,
  output logic                           err,
  // reset source pulses
  input  rcc_pkg::rst_src_t              rst_src,
  // oscillator enable
  output logic                           lsion
);
  import rcc_pkg::*;

  // --------------------
  // internal wires
  // --------------------
  // decoded command
  logic                      cmd_valid;
  logic                      cmd_wr;
  reg_sel_e                  cmd_sel;
  logic [cpu_w-1:0]          cmd_cpu;
  rcc_word_u                 cmd_wdata;
  // status state per core
  rst_src_t [num_cpu-1:0]    flags;
  logic [num_cpu-1:0]        rmvf;

  // request in, command out
  rcc_reg_decode #(
    .num_cpu (num_cpu)
  ) u_decode (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .wr        (wr),
    .addr      (addr),
    .wdata     (wdata),
    .ack       (ack),
    .cmd_valid (cmd_valid),
    .cmd_wr    (cmd_wr),
    .cmd_sel   (cmd_sel),
    .cmd_cpu   (cmd_cpu),
    .cmd_wdata (cmd_wdata)
  );

  // flags, rmvf and lsion
  rcc_rst_flags #(
    .num_cpu (num_cpu)
  ) u_flags (
    .clk       (clk),
    .rst       (rst),
    .rst_src   (rst_src),
    .cmd_valid (cmd_valid),
    .cmd_wr    (cmd_wr),
    .cmd_sel   (cmd_sel),
    .cmd_cpu   (cmd_cpu),
    .cmd_wdata (cmd_wdata),
    .flags     (flags),
    .rmvf      (rmvf),
    .lsion     (lsion)
  );

  // read data and ack
  rcc_read_result #(
    .num_cpu (num_cpu)
  ) u_result (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .cmd_valid (cmd_valid),
    .cmd_wr    (cmd_wr),
    .cmd_sel   (cmd_sel),
    .cmd_cpu   (cmd_cpu),
    .flags     (flags),
    .rmvf      (rmvf),
    .lsion     (lsion),
    .ack       (ack),
    .rdata     (rdata),
    .err       (err)
  );

endmodule

// File: testbench/tb_rcc_vdd_reg.sv
// --------------------
// stimulus and expected values come from testbench/tb_rcc_input.txt
// run from the project root so the relative path resolves
// --------------------
`timescale 1ns/1ps

module tb_rcc_vdd_reg;
  import rcc_pkg::*;

  localparam int num_cpu = 2;
  // negedges to wait for an ack edge
  localparam int wait_limit = 50;

  logic                  clk;
  logic                  rst;
  logic                  req;
  logic                  wr;
  logic [rcc_addr_w-1:0] addr;
  rcc_word_u             wdata;
  rst_src_t              rst_src;
  logic                  ack;
  rcc_word_u             rdata;
  logic                  err;
  logic                  lsion;

  int checks;
  int errors;
  // set when a wait ran out or the file could not be read
  bit hung;

  rcc_vdd_reg #(
    .num_cpu (num_cpu)
  ) i_rcc_vdd_reg (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .wr      (wr),
    .addr    (addr),
    .wdata   (wdata),
    .ack     (ack),
    .rdata   (rdata),
    .err     (err),
    .rst_src (rst_src),
    .lsion   (lsion)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic compare_word(input rcc_word_u got, input rcc_word_u exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s rdata %08h, expected %08h", $time, what, got, exp);
    end else begin
      $display("pass at %0t ns: %s rdata %08h", $time, what, got);
    end
  endtask

  task automatic compare_err(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s err %b, expected %b", $time, what, got, exp);
    end else begin
      $display("pass at %0t ns: %s err %b", $time, what, got);
    end
  endtask

  task automatic compare_lsion(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: lsion %b, expected %b", $time, got, exp);
    end else begin
      $display("pass at %0t ns: lsion %b", $time, got);
    end
  endtask

  // address outside the csr and the per-core status words
  function automatic logic unmapped_addr(input logic [rcc_addr_w-1:0] a);
    logic hit;
    hit = (a == addr_csr);
    for (int k = 0; k < num_cpu; k++) begin
      if (a == addr_rsr_base + rcc_addr_w'(4 * k)) begin
        hit = 1'b1;
      end
    end
    return !hit;
  endfunction

  // --------------------
  // stimulus tasks
  // --------------------
  // one cycle pulse on the reset sources
  task automatic pulse_sources(input rst_src_t src);
    @(posedge clk);
    rst_src <= src;
    @(posedge clk);
    rst_src <= '0;
    $display("pulse %04h applied at %0t ns", src, $time);
  endtask

  // full four-phase access with ack edges sampled at negedge
  task automatic do_access(input logic is_wr, input logic [rcc_addr_w-1:0] a,
                           input rcc_word_u d, output rcc_word_u got_data,
                           output logic got_err);
    int waited;
    got_data = '0;
    got_err  = 1'b0;
    @(negedge clk);
    // previous access must be fully closed
    if (ack !== 1'b0) begin
      errors++;
      $display("ack already high at %0t ns before the request to %02h", $time, a);
    end
    @(posedge clk);
    req   <= 1'b1;
    wr    <= is_wr;
    addr  <= a;
    wdata <= d;
    waited = 0;
    @(negedge clk);
    while ((ack !== 1'b1) && (waited < wait_limit)) begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b1) begin
      hung = 1'b1;
      $display("timeout at %0t ns: no ack for the access to %02h", $time, a);
    end else begin
      got_data = rdata;
      got_err  = err;
      @(posedge clk);
      req <= 1'b0;
      waited = 0;
      @(negedge clk);
      // ack has to follow req down
      while ((ack !== 1'b0) && (waited < wait_limit)) begin
        @(negedge clk);
        waited++;
      end
      if (ack !== 1'b0) begin
        hung = 1'b1;
        $display("timeout at %0t ns: ack stayed high after req dropped", $time);
      end
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int                    fd;
    int                    code;
    logic [7:0]            op;
    logic [8*128-1:0]      line_buf;
    logic [rcc_addr_w-1:0] f_addr;
    logic [rcc_data_w-1:0] f_data;
    rst_src_t              f_src;
    logic                  f_bit;
    rcc_word_u             got_data;
    logic                  got_err;
    checks  = 0;
    errors  = 0;
    hung    = 1'b0;
    rst     = 1'b1;
    req     = 1'b0;
    wr      = 1'b0;
    addr    = '0;
    wdata   = '0;
    rst_src = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    fd = $fopen("testbench/tb_rcc_input.txt", "r");
    if (fd == 0) begin
      hung = 1'b1;
      $display("could not open the stimulus file testbench/tb_rcc_input.txt");
    end
    while ((fd != 0) && !hung && !$feof(fd)) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        break;
      end
      if (op == "#") begin
        // rest of a comment line
        code = $fgets(line_buf, fd);
      end else if (op == "E") begin
        code = $fscanf(fd, "%h", f_src);
        pulse_sources(f_src);
      end else if (op == "W") begin
        code = $fscanf(fd, "%h %h", f_addr, f_data);
        do_access(1'b1, f_addr, f_data, got_data, got_err);
        $display("write %02h data %08h done at %0t ns", f_addr, f_data, $time);
        if (!hung) begin
          // a write returns zero data
          compare_word(got_data, '0, $sformatf("write %02h", f_addr));
          compare_err(got_err, unmapped_addr(f_addr), $sformatf("write %02h", f_addr));
        end
      end else if (op == "R") begin
        code = $fscanf(fd, "%h %h %b", f_addr, f_data, f_bit);
        do_access(1'b0, f_addr, '0, got_data, got_err);
        if (!hung) begin
          compare_word(got_data, f_data, $sformatf("read %02h", f_addr));
          compare_err(got_err, f_bit, $sformatf("read %02h", f_addr));
        end
      end else if (op == "L") begin
        code = $fscanf(fd, "%b", f_bit);
        @(negedge clk);
        compare_lsion(lsion, f_bit);
      end else begin
        errors++;
        $display("unknown operation %s in the stimulus file", op);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("checks %0d, errors %0d, aborted %0d", checks, errors, hung);
    if ((errors == 0) && !hung && (checks > 0)) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: testbench/tb_rcc_input.txt
# E src_hex | W addr_hex data_hex | R addr_hex exp_data_hex exp_err | L exp_lsion
# status word: src bit i (i>=1) at bit i+18, obl at 17, rmvf at 16
# after reset only por is set
R 04 00800000 0
R 08 00800000 0
R 00 00000000 0
L 0
# pin and iwdg1, both cores
E 0110
R 04 04C00000 0
R 08 04C00000 0
# obl and lpwr2 accumulate
E 2001
R 04 84C20000 0
R 08 84C20000 0
# sft2
E 0080
R 04 86C20000 0
R 08 86C20000 0
# core 0 remove flags
W 04 00010000
R 04 00010000 0
R 08 86C20000 0
# bor while core 0 rmvf is set
E 0008
R 04 00010000 0
R 08 86E20000 0
W 04 00000000
R 04 00000000 0
# d1 and wwdg1 after rmvf is released
E 0402
R 04 10080000 0
R 08 96EA0000 0
# flags in core 1 are not writable
W 08 FFFE0000
R 08 96EA0000 0
# lsion set, clear, upper bits ignored
W 00 00000001
R 00 00000001 0
L 1
W 00 00000000
R 00 00000000 0
L 0
W 00 FFFFFFFE
R 00 00000000 0
L 0
W 00 FFFFFFFF
L 1
R 00 00000001 0
W 00 00000000
L 0
# unknown, misaligned and missing core addresses
R 40 00000000 1
R 05 00000000 1
R 01 00000000 1
R 0C 00000000 1
W 40 FFFFFFFF
W 05 00010000
W 06 00000001
R 00 00000000 0
R 04 10080000 0
R 08 96EA0000 0
L 0

// File: src.f
source/rcc_pkg.sv
source/rcc_reg_decode.sv
source/rcc_rst_flags.sv
source/rcc_read_result.sv
source/rcc_vdd_reg.sv
testbench/tb_rcc_vdd_reg.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module tb_rcc_vdd_reg -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
